// File: hdl/cmd_pkg.sv
// shared widths, opcodes, response codes and timing constants for the host command processor
package cmd_pkg;

   typedef logic [7:0] byte_t;           // command or spi byte
   typedef logic [31:0] word_t;          // usb response word
   typedef logic signed [11:0] thresh_t; // trigger threshold
   typedef logic [2:0] chip_sel_t;       // spi chip number

   // spi sequencer states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CS_SETUP,
      ST_LOAD,
      ST_WAIT_READY,
      ST_WAIT_RX,
      ST_CS_HOLD,
      ST_DONE
   } spi_state_t;

   // opcodes in byte 0
   localparam byte_t OP_REG       = 8'd2;
   localparam byte_t OP_SPI       = 8'd3;
   localparam byte_t OP_PLLRESET  = 8'd5;
   localparam byte_t OP_THRESH    = 8'd8;
   localparam byte_t OP_BOARDOUT  = 8'd10;

   // register sub-ops in byte 1
   localparam byte_t REG_VERSION  = 8'd0;
   localparam byte_t REG_BOARDIN  = 8'd1;
   localparam byte_t REG_FANPWM   = 8'd21;

   localparam word_t FW_VERSION    = 32'd31;
   localparam word_t RESP_PLLRESET = 32'd5;
   localparam word_t RESP_THRESH   = 32'd8;

   localparam int CMD_BYTES       = 8;
   localparam int CMD_CNT_W       = $clog2(CMD_BYTES);
   localparam int CS_SETUP_CYCLES = 10; // cs low before first byte
   localparam int CS_HOLD_CYCLES  = 35; // after last read-back
   localparam int SPI_WAIT_W      = 6;  // wide enough for both waits

   localparam logic [11:0] THRESH_OFFSET = 12'd128;
   localparam logic [11:0] THRESH_ROUND  = 12'd8;

endpackage

// File: hdl/cmd_receiver.sv
// collects 8-byte host commands from the usb stream and starts the matching handler
`timescale 1ns/1ns
module cmd_receiver
   import cmd_pkg::*;
(
   input  logic  clk50,
   input  logic  pllreset2,
   input  logic  i_tvalid,
   input  byte_t i_tdata,
   input  logic  i_done,                   // response beat accepted
   output logic  o_tready,
   output byte_t o_cmd_bytes [CMD_BYTES],
   output logic  o_settings_start,
   output logic  o_spi_start
);

   logic                 busy;     // a handler or the transmitter owns the command
   logic [CMD_CNT_W-1:0] rx_count;
   logic                 last_byte;

   assign o_tready  = ~busy;
   assign last_byte = (rx_count == CMD_CNT_W'(CMD_BYTES - 1));

   always_ff @(posedge clk50) begin
      o_settings_start <= 1'b0;
      o_spi_start      <= 1'b0;
      if (pllreset2) begin
         busy     <= 1'b0;
         rx_count <= '0;
      end else if (busy) begin
         if (i_done) busy <= 1'b0; // reopen input
      end else if (i_tvalid) begin
         if (last_byte) begin
            rx_count <= '0;
            // byte 0 is already held by now
            case (o_cmd_bytes[0])
               OP_REG, OP_PLLRESET, OP_THRESH, OP_BOARDOUT: begin
                  o_settings_start <= 1'b1;
                  busy             <= 1'b1;
               end
               OP_SPI: begin
                  o_spi_start <= 1'b1;
                  busy        <= 1'b1;
               end
               default: busy <= 1'b0; // unknown opcode is dropped
            endcase
         end else begin
            rx_count <= rx_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk50) begin
      if (o_tready && i_tvalid) o_cmd_bytes[rx_count] <= i_tdata;
   end

endmodule

// File: hdl/settings_regs.sv
// executes register, pll reset, threshold and board output commands and drives the fan pwm
`timescale 1ns/1ns
module settings_regs
   import cmd_pkg::*;
(
   input  logic    clk50,
   input  logic    pllreset2,
   input  logic    i_start,
   input  byte_t   i_cmd_bytes [CMD_BYTES],
   input  byte_t   i_boardin,
   output logic    o_resp_valid,
   output word_t   o_resp_word,
   output thresh_t o_lowerthresh,
   output thresh_t o_upperthresh,
   output byte_t   o_boardout,
   output logic    o_pllreset,
   output logic    o_fan
);

   byte_t       boardin_meta;
   byte_t       boardin_sync;
   byte_t       fan_duty;
   byte_t       fan_cnt;
   logic [11:0] thr_lo_base;
   logic [11:0] thr_hi_base;
   byte_t       opcode;
   byte_t       sub_op;

   assign opcode = i_cmd_bytes[0];
   assign sub_op = i_cmd_bytes[1];

   // byte1 is the threshold centre and byte2 the half width
   assign thr_lo_base = {4'd0, i_cmd_bytes[1]} - {4'd0, i_cmd_bytes[2]} - THRESH_OFFSET;
   assign thr_hi_base = {4'd0, i_cmd_bytes[1]} + {4'd0, i_cmd_bytes[2]} - THRESH_OFFSET;

   always_ff @(posedge clk50) begin
      boardin_meta <= i_boardin; // board pins are asynchronous
      boardin_sync <= boardin_meta;
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_resp_valid  <= 1'b0;
         o_pllreset    <= 1'b0;
         o_lowerthresh <= '0;
         o_upperthresh <= '0;
         o_boardout    <= '0;
         fan_duty      <= '0;
      end else begin
         o_resp_valid <= i_start; // every settings opcode answers
         o_pllreset   <= i_start && (opcode == OP_PLLRESET);
         if (i_start) begin
            case (opcode)
               OP_REG: begin
                  if (sub_op == REG_FANPWM) fan_duty <= i_cmd_bytes[2];
               end
               OP_THRESH: begin
                  o_lowerthresh <= thresh_t'((thr_lo_base << 4) + THRESH_ROUND);
                  o_upperthresh <= thresh_t'((thr_hi_base << 4) + THRESH_ROUND);
               end
               OP_BOARDOUT: o_boardout[i_cmd_bytes[1][2:0]] <= i_cmd_bytes[2][0];
               default: ;
            endcase
         end
      end
   end

   // response word from the values held before this command's writes
   always_ff @(posedge clk50) begin
      if (i_start) begin
         case (opcode)
            OP_REG: begin
               case (sub_op)
                  REG_VERSION: o_resp_word <= FW_VERSION;
                  REG_BOARDIN: o_resp_word <= {24'd0, boardin_sync};
                  REG_FANPWM:  o_resp_word <= {24'd0, fan_duty}; // previous duty
                  default:     o_resp_word <= '0;
               endcase
            end
            OP_PLLRESET: o_resp_word <= RESP_PLLRESET;
            OP_THRESH:   o_resp_word <= RESP_THRESH;
            OP_BOARDOUT: o_resp_word <= {24'd0, o_boardout};
            default:     o_resp_word <= '0;
         endcase
      end
   end

   // fan pwm with a period of 256 clocks
   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         fan_cnt <= '0;
         o_fan   <= 1'b0;
      end else begin
         fan_cnt <= fan_cnt + 8'd1;
         o_fan   <= (fan_cnt < fan_duty);
      end
   end

endmodule

// File: hdl/spi_sequencer.sv
// runs one spi transaction of 2 to 4 bytes for a host command and returns the read-back
`timescale 1ns/1ns
module spi_sequencer
   import cmd_pkg::*;
(
   input  logic      clk50,
   input  logic      pllreset2,
   input  logic      i_start,
   input  byte_t     i_cmd_bytes [CMD_BYTES],
   input  logic      i_spi_txready,
   input  logic      i_spi_rxdv,
   input  byte_t     i_spirx,
   output byte_t     o_spitx,
   output logic      o_spi_txdv,
   output byte_t     o_spics,
   output chip_sel_t o_spimisossel,
   output logic      o_resp_valid,
   output word_t     o_resp_word
);

   spi_state_t            state;
   logic [SPI_WAIT_W-1:0] wait_cnt;
   logic [1:0]            byte_idx;  // byte being sent counted from cmd byte 2
   logic [1:0]            last_idx;
   chip_sel_t             chip;

   assign chip = i_cmd_bytes[1][2:0];

   // byte 7 gives the byte count clamped to 2..4
   always_comb begin
      if (i_cmd_bytes[7] >= 8'd4) last_idx = 2'd3;
      else if (i_cmd_bytes[7] == 8'd3) last_idx = 2'd2;
      else last_idx = 2'd1;
   end

   always_ff @(posedge clk50) begin
      o_spi_txdv   <= 1'b0; // one-cycle strobes
      o_resp_valid <= 1'b0;
      if (pllreset2) begin
         state         <= ST_IDLE;
         wait_cnt      <= '0;
         byte_idx      <= '0;
         o_spics       <= 8'hff;
         o_spimisossel <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  o_spics[chip] <= 1'b0;
                  o_spimisossel <= chip; // listen to the same chip
                  wait_cnt      <= '0;
                  byte_idx      <= '0;
                  state         <= ST_CS_SETUP;
               end
            end
            ST_CS_SETUP: begin
               if (wait_cnt == SPI_WAIT_W'(CS_SETUP_CYCLES - 1)) state <= ST_LOAD;
               else wait_cnt <= wait_cnt + 1'b1;
            end
            ST_LOAD: state <= ST_WAIT_READY;
            ST_WAIT_READY: begin
               if (i_spi_txready) begin
                  o_spi_txdv <= 1'b1;
                  state      <= ST_WAIT_RX;
               end
            end
            ST_WAIT_RX: begin
               if (i_spi_rxdv) begin
                  if (byte_idx == last_idx) begin
                     wait_cnt <= '0;
                     state    <= ST_CS_HOLD;
                  end else begin
                     byte_idx <= byte_idx + 1'b1;
                     state    <= ST_LOAD;
                  end
               end
            end
            ST_CS_HOLD: begin
               if (wait_cnt == SPI_WAIT_W'(CS_HOLD_CYCLES - 1)) begin
                  o_spics <= 8'hff;
                  state   <= ST_DONE;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            ST_DONE: begin
               o_resp_valid <= 1'b1;
               state        <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // tx byte and read-back capture
   always_ff @(posedge clk50) begin
      if (state == ST_IDLE && i_start) begin
         o_resp_word <= '0;
      end else if (state == ST_LOAD) begin
         o_spitx <= i_cmd_bytes[3'd2 + 3'(byte_idx)];
      end else if (state == ST_WAIT_RX && i_spi_rxdv) begin
         if (byte_idx == last_idx - 2'd1) o_resp_word[15:8] <= i_spirx;
         if (byte_idx == last_idx) o_resp_word[7:0] <= i_spirx;
      end
   end

endmodule

// File: hdl/response_tx.sv
// sends a handler's 32-bit response word as one usb stream beat and flags completion
`timescale 1ns/1ns
module response_tx
   import cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   input  logic       i_settings_valid,
   input  word_t      i_settings_word,
   input  logic       i_spi_valid,
   input  word_t      i_spi_word,
   input  logic       i_tready,
   output logic       o_tvalid,
   output word_t      o_tdata,
   output logic [3:0] o_tkeep,
   output logic       o_tlast,
   output logic       o_done
);

   // every response is a single full beat
   assign o_tkeep = 4'b1111;
   assign o_tlast = 1'b1;

   always_ff @(posedge clk50) begin
      o_done <= 1'b0;
      if (pllreset2) begin
         o_tvalid <= 1'b0;
      end else if (o_tvalid) begin
         if (i_tready) begin
            o_tvalid <= 1'b0;
            o_done   <= 1'b1; // lets the receiver take the next command
         end
      end else if (i_settings_valid || i_spi_valid) begin
         o_tvalid <= 1'b1;
      end
   end

   // only one handler can strobe at a time
   always_ff @(posedge clk50) begin
      if (!o_tvalid) begin
         if (i_settings_valid) o_tdata <= i_settings_word;
         else if (i_spi_valid) o_tdata <= i_spi_word;
      end
   end

endmodule

// File: hdl/command_processor.sv
// top of the host command processor, wiring receiver, both handlers and the usb transmitter
`timescale 1ns/1ns
module command_processor
   import cmd_pkg::*;
(
   input  logic       clk50,
   input  logic       pllreset2,
   input  logic       i_tvalid,    // usb bytes in
   input  byte_t      i_tdata,
   output logic       o_tready,
   output logic       o_tvalid,    // usb words out
   output word_t      o_tdata,
   output logic [3:0] o_tkeep,
   output logic       o_tlast,
   input  logic       i_tready,
   input  byte_t      i_boardin,
   output byte_t      o_spitx,
   output logic       o_spi_txdv,
   input  logic       i_spi_txready,
   input  logic       i_spi_rxdv,
   input  byte_t      i_spirx,
   output byte_t      o_spics,
   output chip_sel_t  o_spimisossel,
   output thresh_t    o_lowerthresh,
   output thresh_t    o_upperthresh,
   output byte_t      o_boardout,
   output logic       o_pllreset,
   output logic       o_fan
);

   byte_t cmd_bytes [CMD_BYTES];
   logic  settings_start;
   logic  spi_start;
   logic  settings_valid;
   word_t settings_word;
   logic  spi_valid;
   word_t spi_word;
   logic  done;

   cmd_receiver i_cmd_receiver (
      .clk50            (clk50),
      .pllreset2        (pllreset2),
      .i_tvalid         (i_tvalid),
      .i_tdata          (i_tdata),
      .i_done           (done),
      .o_tready         (o_tready),
      .o_cmd_bytes      (cmd_bytes),
      .o_settings_start (settings_start),
      .o_spi_start      (spi_start)
   );

   settings_regs i_settings_regs (
      .clk50         (clk50),
      .pllreset2     (pllreset2),
      .i_start       (settings_start),
      .i_cmd_bytes   (cmd_bytes),
      .i_boardin     (i_boardin),
      .o_resp_valid  (settings_valid),
      .o_resp_word   (settings_word),
      .o_lowerthresh (o_lowerthresh),
      .o_upperthresh (o_upperthresh),
      .o_boardout    (o_boardout),
      .o_pllreset    (o_pllreset),
      .o_fan         (o_fan)
   );

   spi_sequencer i_spi_sequencer (
      .clk50         (clk50),
      .pllreset2     (pllreset2),
      .i_start       (spi_start),
      .i_cmd_bytes   (cmd_bytes),
      .i_spi_txready (i_spi_txready),
      .i_spi_rxdv    (i_spi_rxdv),
      .i_spirx       (i_spirx),
      .o_spitx       (o_spitx),
      .o_spi_txdv    (o_spi_txdv),
      .o_spics       (o_spics),
      .o_spimisossel (o_spimisossel),
      .o_resp_valid  (spi_valid),
      .o_resp_word   (spi_word)
   );

   response_tx i_response_tx (
      .clk50            (clk50),
      .pllreset2        (pllreset2),
      .i_settings_valid (settings_valid),
      .i_settings_word  (settings_word),
      .i_spi_valid      (spi_valid),
      .i_spi_word       (spi_word),
      .i_tready         (i_tready),
      .o_tvalid         (o_tvalid),
      .o_tdata          (o_tdata),
      .o_tkeep          (o_tkeep),
      .o_tlast          (o_tlast),
      .o_done           (done)
   );

endmodule

// File: sim/command_processor_assert.sv
// concurrent checks on the usb output beat and spi strobe for binding into the command processor
`timescale 1ns/1ns
module command_processor_assert
   import cmd_pkg::*;
(
   input logic  clk50,
   input logic  pllreset2,
   input logic  o_tvalid,
   input word_t o_tdata,
   input logic  i_tready,
   input logic  o_tready,
   input logic  o_spi_txdv,
   input byte_t o_spics
);

   int fail_count = 0; // assertion failures so far

   a_beat_stable: assert property (@(posedge clk50) disable iff (pllreset2)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata))
      else begin
         $error("usb beat dropped or changed while stalled");
         fail_count++;
      end

   // exactly one chip selected when a byte starts
   a_txdv_cs: assert property (@(posedge clk50) disable iff (pllreset2)
      $rose(o_spi_txdv) |-> $countones(~o_spics) == 1)
      else begin
         $error("spi byte started without a single chip select low");
         fail_count++;
      end

   a_input_blocked: assert property (@(posedge clk50) disable iff (pllreset2)
      o_tvalid |-> !o_tready)
      else begin
         $error("usb input open while a response is pending");
         fail_count++;
      end

endmodule

bind command_processor command_processor_assert i_command_processor_assert (.*);

// File: sim/tb_command_processor.sv
// testbench replaying the tests file against the command processor with an spi master model
`timescale 1ns/1ns
module tb_command_processor
   import cmd_pkg::*;
();

   localparam int CLK_PERIOD      = 40;
   localparam int DRIVE_DLY       = 5;
   localparam int NUM_TESTS       = 20;
   localparam int FIELDS          = 14;   // hex words per test line
   localparam int RESP_LIMIT      = 1000; // cycles allowed for one response beat
   localparam int QUIET_CYCLES    = 100;  // window for a dropped command
   localparam int WATCHDOG_CYCLES = 2000 * NUM_TESTS;

   logic       clk50;
   logic       pllreset2;
   logic       i_tvalid;
   byte_t      i_tdata;
   logic       o_tready;
   logic       o_tvalid;
   word_t      o_tdata;
   logic [3:0] o_tkeep;
   logic       o_tlast;
   logic       i_tready;
   byte_t      i_boardin;
   byte_t      o_spitx;
   logic       o_spi_txdv;
   logic       i_spi_txready;
   logic       i_spi_rxdv;
   byte_t      i_spirx;
   byte_t      o_spics;
   chip_sel_t  o_spimisossel;
   thresh_t    o_lowerthresh;
   thresh_t    o_upperthresh;
   byte_t      o_boardout;
   logic       o_pllreset;
   logic       o_fan;

   logic [31:0] tests [NUM_TESTS*FIELDS];
   integer      seed;
   int          errors;
   int          passed;
   int          failed;
   int          pll_pulses;
   int          spi_bytes;
   int          cur_test;
   logic        check_cs;   // spi test running
   chip_sel_t   cs_chip;
   byte_t       exp_cs;
   byte_t       rx_byte;

   command_processor i_command_processor (.*);

   initial begin
      clk50 = 1'b0;
      forever #(CLK_PERIOD/2) clk50 = ~clk50;
   end

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("watchdog expired before all tests finished");
      $display("Errors found");
      $finish;
   end

   always @(posedge clk50) begin
      if (o_pllreset) pll_pulses++;
   end

   // spi master model returning each sent byte inverted two cycles after txdv
   always @(posedge clk50) begin
      if (o_spi_txdv) begin
         rx_byte = ~o_spitx;
         exp_cs  = ~(8'h01 << cs_chip);
         spi_bytes++;
         if (check_cs) begin
            assert (o_spics == exp_cs)
               else report_mismatch("chip select", cur_test, o_spics, exp_cs);
            assert (o_spimisossel == cs_chip)
               else report_mismatch("miso select", cur_test, o_spimisossel, cs_chip);
         end
         @(posedge clk50);
         #DRIVE_DLY;
         i_spirx    = rx_byte;
         i_spi_rxdv = 1'b1;
         @(posedge clk50);
         #DRIVE_DLY;
         i_spi_rxdv = 1'b0;
      end
   end

   task automatic report_mismatch(input string what, input int t, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("mismatch at %0t ns: test %0d %s got %0h expected %0h", $time, t, what, got, exp);
      errors++;
   endtask

   task automatic send_command(input int base);
      int gap;
      for (int i = 0; i < 8; i++) begin
         gap = $unsigned($random(seed)) % 3; // idle cycles before the byte
         repeat (gap) begin
            @(posedge clk50);
            #DRIVE_DLY;
         end
         i_tvalid = 1'b1;
         i_tdata  = tests[base + i][7:0];
         do @(posedge clk50); while (!o_tready);
         #DRIVE_DLY;
         i_tvalid = 1'b0;
      end
   endtask

   task automatic wait_response(output word_t got, output logic [4:0] tail, output logic seen);
      int cycles;
      cycles = 0;
      seen   = 1'b0;
      got    = '0;
      tail   = '0;
      while (!seen && cycles < RESP_LIMIT) begin
         @(posedge clk50);
         if (o_tvalid && i_tready) begin
            got  = o_tdata;
            tail = {o_tlast, o_tkeep};
            seen = 1'b1;
         end
         #DRIVE_DLY;
         i_tready = ($unsigned($random(seed)) % 4) != 0; // stall about one cycle in four
         cycles++;
      end
      i_tready = 1'b0;
   endtask

   task automatic check_quiet(input int t, input bit fan_only);
      repeat (fan_only ? 256 : QUIET_CYCLES) begin
         @(posedge clk50);
         if (fan_only) begin
            assert (o_fan == 1'b0) else report_mismatch("o_fan at zero duty", t, o_fan, 0);
         end else begin
            assert (o_tvalid == 1'b0)
               else $display("test %0d: a response came for a dropped command", t);
            if (o_tvalid) errors++;
         end
      end
      #DRIVE_DLY;
   endtask

   initial begin
      int         base;
      logic [7:0] flags;
      word_t      got;
      logic [4:0] tail;
      logic       seen;
      int         errs_before;
      byte_t      exp_bytes;

      seed = 32'h6af7;
      errors = 0;
      passed = 0;
      failed = 0;
      pll_pulses = 0;
      spi_bytes = 0;
      cur_test = 0;
      check_cs = 1'b0;
      cs_chip = '0;
      pllreset2 = 1'b1;
      i_tvalid = 1'b0;
      i_tdata = '0;
      i_tready = 1'b0;
      i_boardin = '0;
      i_spi_txready = 1'b1;
      i_spi_rxdv = 1'b0;
      i_spirx = '0;
      $readmemh("sim/command_processor_tests.txt", tests);
      repeat (2) @(posedge clk50);
      #DRIVE_DLY;
      pllreset2 = 1'b0;
      assert (!o_tvalid && !o_spi_txdv && !o_pllreset && !o_fan && o_spics == 8'hff &&
              o_tready && o_lowerthresh == 0 && o_upperthresh == 0 && o_boardout == 0)
         else report_mismatch("outputs after reset", 0, 0, 0);

      for (int t = 0; t < NUM_TESTS; t++) begin
         base        = t * FIELDS;
         flags       = tests[base + 8][7:0];
         errs_before = errors;
         cur_test    = t;
         pll_pulses  = 0;
         spi_bytes   = 0;
         cs_chip     = tests[base + 1][2:0];
         check_cs    = flags[5];
         i_boardin   = tests[base + 9][7:0];
         send_command(base);
         if (flags[0]) begin
            wait_response(got, tail, seen);
            assert (seen) else $display("test %0d: no response within %0d cycles", t, RESP_LIMIT);
            if (!seen) begin
               errors++;
            end else begin
               assert (got == tests[base + 10])
                  else report_mismatch("response", t, got, tests[base + 10]);
               assert (tail == 5'h1f)
                  else report_mismatch("last and keep", t, tail, 5'h1f);
            end
         end else begin
            check_quiet(t, 1'b0);
         end
         if (flags[1]) begin
            assert (o_lowerthresh == tests[base + 11][11:0])
               else report_mismatch("lower threshold", t, {20'd0, o_lowerthresh}, tests[base + 11]);
            assert (o_upperthresh == tests[base + 12][11:0])
               else report_mismatch("upper threshold", t, {20'd0, o_upperthresh}, tests[base + 12]);
         end
         if (flags[2]) begin
            assert (o_boardout == tests[base + 13][7:0])
               else report_mismatch("boardout", t, o_boardout, tests[base + 13]);
         end
         assert (pll_pulses == int'(flags[3]))
            else report_mismatch("pll reset pulses", t, pll_pulses, flags[3]);
         if (flags[4]) check_quiet(t, 1'b1);
         exp_bytes = flags[5] ? tests[base + 7][7:0] : 8'd0;
         assert (spi_bytes == exp_bytes) else report_mismatch("spi bytes", t, spi_bytes, exp_bytes);
         assert (o_spics == 8'hff) else report_mismatch("chip select idle", t, o_spics, 8'hff);
         check_cs = 1'b0;
         if (errors == errs_before) begin
            passed++;
            $display("test %0d passed", t);
         end else begin
            failed++;
            $display("test %0d failed", t);
         end
      end

      errors += i_command_processor.i_command_processor_assert.fail_count;
      $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passed, failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sim/command_processor_tests.txt
// b0..b7 command bytes, flags (bit0 response, 1 thresholds, 2 boardout, 3 pll pulse, 4 fan idle, 5 spi)
// then boardin, expected response, expected lower and upper threshold, expected boardout
02 00 00 00 00 00 00 00  11 a5  0000001f  000 000  00
02 01 00 00 00 00 00 00  01 5c  0000005c  000 000  00
02 07 00 00 00 00 00 00  01 5c  00000000  000 000  00
02 15 80 00 00 00 00 00  01 00  00000000  000 000  00
02 15 40 00 00 00 00 00  01 00  00000080  000 000  00
02 15 00 00 00 00 00 00  01 00  00000040  000 000  00
08 90 10 00 00 00 00 00  03 00  00000008  008 208  00
08 40 20 00 00 00 00 00  03 00  00000008  a08 e08  00
05 00 00 00 00 00 00 00  09 00  00000005  000 000  00
0a 03 01 00 00 00 00 00  05 00  00000000  000 000  08
0a 00 01 00 00 00 00 00  05 00  00000008  000 000  09
0a 07 01 00 00 00 00 00  05 00  00000009  000 000  89
0a 03 00 00 00 00 00 00  05 00  00000089  000 000  81
0a 00 00 00 00 00 00 00  05 00  00000081  000 000  80
03 02 3c c3 00 00 00 02  21 00  0000c33c  000 000  00
03 05 11 22 33 00 00 03  21 00  0000ddcc  000 000  00
03 07 a1 b2 c3 d4 00 04  21 00  00003c2b  000 000  00
07 12 34 00 00 00 00 00  00 00  00000000  000 000  00
ff 00 00 00 00 00 00 00  00 00  00000000  000 000  00
02 01 00 00 00 00 00 00  01 3e  0000003e  000 000  00

// File: vlog.f
hdl/cmd_pkg.sv
hdl/cmd_receiver.sv
hdl/settings_regs.sv
hdl/spi_sequencer.sv
hdl/response_tx.sv
hdl/command_processor.sv
sim/command_processor_assert.sv
sim/tb_command_processor.sv

// File: Bender.yml
package:
  name: command_processor

sources:
  - files:
      - hdl/cmd_pkg.sv
      - hdl/cmd_receiver.sv
      - hdl/settings_regs.sv
      - hdl/spi_sequencer.sv
      - hdl/response_tx.sv
      - hdl/command_processor.sv
  - target: simulation
    files:
      - sim/command_processor_assert.sv
      - sim/tb_command_processor.sv
